// File: all.f
logic/uart_cfg_pkg.sv
logic/cmd_pkg.sv
logic/rx_link_if.sv
logic/uart_rx.sv
logic/cmd_engine.sv
logic/uart_tx.sv
logic/uart_cmd_top.sv
bench/uart_cmd_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := uart_cmd_tb
FLIST    := all.f
OBJ_DIR  := obj_dir
LOG      := run.log
PASS_MSG := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/uart_patterns.txt
# Kind and hex value: S send byte, B send byte with low stop bit, E expected output byte,
# C expected o_err_cnt, W wait for idle output; consecutive S and B lines run with no gap
S 41
E 41
S 5A
E 5A
W
C 00
S 85
S 3C
E 39
W
S 90
E 03
S A3
S F7
S 90
E 03
W
B 33
W
C 01
S 12
E 17
W
S 00
S 11
S 22
S 63
S 7F
S 5E
E 05
E 14
E 27
E 66
E 7A
E 5B
W
C 01
S 90
E 0A
W
C 01

// File: bench/uart_cmd_tb.sv
`timescale 1ns/100ps

module uart_cmd_tb;
    import uart_cfg_pkg::*;

    localparam int IDLE_RUN = 12 * CLK_PER_BIT;   // Longer than any high run inside a frame

    logic                 i_CLK;
    logic                 i_RST;
    logic                 i_rxd;
    logic                 o_txd;
    logic [ERR_CNT_W-1:0] o_err_cnt;

    logic [7:0] rec_kind [$];
    logic [7:0] rec_val  [$];
    logic [7:0] exp_q    [$];   // Output bytes still to come, in order
    int         err_cnt;
    int         chk_cnt;
    int         cycles;
    int         cycle_limit;
    int         idle_run;

    uart_cmd_top UUT
    (
        .i_CLK     (i_CLK),
        .i_RST     (i_RST),
        .i_rxd     (i_rxd),
        .o_txd     (o_txd),
        .o_err_cnt (o_err_cnt)
    );

    always #10 i_CLK = ~i_CLK;

    always @(posedge i_CLK)
    begin
        cycles = cycles + 1;
        if ((cycle_limit != 0) && (cycles >= cycle_limit))
        begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Length of the current mark run on the output line
    always @(negedge i_CLK)
    begin
        if (o_txd === 1'b1)
            idle_run = idle_run + 1;
        else
            idle_run = 0;
    end

    function automatic bit load_patterns();
        int         fd;
        string      line;
        logic [7:0] kind;
        logic [7:0] val;
        bit         ok;
        ok = 1'b1;
        fd = $fopen("bench/uart_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the pattern file bench/uart_patterns.txt");
            return 1'b0;
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() == 0)
                continue;
            kind = line.getc(0);
            val  = 8'h00;
            if ((kind == "#") || (kind == 8'h0a) || (kind == 8'h0d) || (kind == " "))
                continue;   // Comment or blank
            if ((kind != "W") && ($sscanf(line.substr(1, line.len() - 1), "%h", val) != 1))
            begin
                $display("Pattern line has no value: %s", line);
                ok = 1'b0;
            end
            else if ((kind == "S") || (kind == "B") || (kind == "C") || (kind == "W"))
            begin
                rec_kind.push_back(kind);
                rec_val.push_back(val);
            end
            else if (kind == "E")
            begin
                exp_q.push_back(val);
                rec_kind.push_back(kind);
                rec_val.push_back(val);
            end
            else
            begin
                $display("Unknown pattern record: %s", line);
                ok = 1'b0;
            end
        end
        $fclose(fd);
        return ok;
    endfunction

    // One serial bit, changed just after the clock edge
    task automatic drive_bit(input logic v);
        @(posedge i_CLK);
        #1;
        i_rxd = v;
        repeat (CLK_PER_BIT - 1) @(posedge i_CLK);
    endtask

    task automatic send_frame(input logic [7:0] b, input logic stop_good);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++)
            drive_bit(b[i]);    // LSB first
        drive_bit(stop_good);
        if (!stop_good)
            drive_bit(1'b1);    // Back to mark so the receiver rearms
    endtask

    task automatic wait_output_idle();
        repeat (2 * CLK_PER_BIT) @(posedge i_CLK);
        while (idle_run < IDLE_RUN)
            @(posedge i_CLK);
        #1;
    endtask

    task automatic check_err_cnt(input logic [7:0] want);
        chk_cnt++;
        if (o_err_cnt !== want)
        begin
            err_cnt++;
            $display("[FAIL] %0t: o_err_cnt expected %0d, seen %0d", $time, want, o_err_cnt);
        end
    endtask

    task automatic read_frame(output logic [7:0] b, output logic framed);
        int i;
        repeat (HALF_BIT) @(negedge i_CLK);
        framed = (o_txd === 1'b0);  // Start bit still low mid-bit
        for (i = 0; i < 8; i++)
        begin
            repeat (CLK_PER_BIT) @(negedge i_CLK);
            b[i] = o_txd;
        end
        repeat (CLK_PER_BIT) @(negedge i_CLK);
        framed = framed && (o_txd === 1'b1);
    endtask

    task automatic compare_output(input logic [7:0] got);
        logic [7:0] want;
        chk_cnt++;
        if (exp_q.size() == 0)
        begin
            err_cnt++;
            $display("Unexpected output byte %02h at %0t, none was expected", got, $time);
        end
        else
        begin
            want = exp_q.pop_front();
            if (got !== want)
            begin
                err_cnt++;
                $display("[FAIL] %0t: output byte expected %02h, seen %02h", $time, want, got);
            end
        end
    endtask

    initial
    begin : monitor
        logic [7:0] got;
        logic       framed;
        @(posedge i_RST);
        forever
        begin
            @(negedge i_CLK);
            if (o_txd === 1'b0)
            begin
                read_frame(got, framed);
                if (framed)
                    compare_output(got);
                else
                begin
                    err_cnt++;
                    $display("Output frame near %0t has a bad start or stop bit", $time);
                end
            end
        end
    end

    initial
    begin : stimulus
        int   n;
        int   gap;
        logic prev_frame;
        i_CLK       = 1'b0;
        i_RST       = 1'b0;
        i_rxd       = 1'b1;
        err_cnt     = 0;
        chk_cnt     = 0;
        cycles      = 0;
        cycle_limit = 0;
        idle_run    = 0;
        prev_frame  = 1'b0;
        void'($urandom(32'h105e_3934));
        if (load_patterns())
        begin
            cycle_limit = rec_kind.size() * 12 * CLK_PER_BIT * 2;
            repeat (2) @(posedge i_CLK);
            #1;
            i_RST = 1'b1;
            for (n = 0; n < rec_kind.size(); n++)
            begin
                case (rec_kind[n])
                    "S", "B":
                    begin
                        if (!prev_frame)
                        begin
                            gap = int'($urandom % 21);
                            repeat (gap) @(posedge i_CLK);
                        end
                        send_frame(rec_val[n], rec_kind[n] == "S");
                        prev_frame = 1'b1;
                    end
                    "C":
                    begin
                        check_err_cnt(rec_val[n]);
                        prev_frame = 1'b0;
                    end
                    "W":
                    begin
                        wait_output_idle();
                        prev_frame = 1'b0;
                    end
                    default: prev_frame = 1'b0;    // E values queued at load
                endcase
            end
        end
        else
            err_cnt++;
        while (exp_q.size() != 0)
        begin
            err_cnt++;
            $display("Expected output byte %02h never arrived", exp_q.pop_front());
        end
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: logic/uart_cmd_top.sv
`timescale 1ns/100ps

module uart_cmd_top
(
    input  logic                              i_CLK,
    input  logic                              i_RST,
    input  logic                              i_rxd,
    output logic                              o_txd,
    output logic [uart_cfg_pkg::ERR_CNT_W-1:0] o_err_cnt
);
    import cmd_pkg::*;

    logic  tx_valid;
    byte_t tx_data;
    logic  tx_credit;

    rx_link_if u_lnk ();

    uart_rx u_rx
    (
        .i_CLK     (i_CLK),
        .i_RST     (i_RST),
        .i_rxd     (i_rxd),
        .o_err_cnt (o_err_cnt),
        .lnk       (u_lnk.src)
    );

    cmd_engine u_eng
    (
        .i_CLK       (i_CLK),
        .i_RST       (i_RST),
        .lnk         (u_lnk.snk),
        .o_tx_valid  (tx_valid),
        .o_tx_data   (tx_data),
        .i_tx_credit (tx_credit)
    );

    uart_tx u_tx
    (
        .i_CLK       (i_CLK),
        .i_RST       (i_RST),
        .i_tx_valid  (tx_valid),
        .i_tx_data   (tx_data),
        .o_tx_credit (tx_credit),
        .o_txd       (o_txd)
    );

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/100ps

module uart_tx
(
    input  logic           i_CLK,
    input  logic           i_RST,
    input  logic           i_tx_valid,
    input  cmd_pkg::byte_t i_tx_data,
    output logic           o_tx_credit,
    output logic           o_txd
);
    import uart_cfg_pkg::*;
    import cmd_pkg::*;

    byte_t                hold_q;
    logic                 hold_full;
    byte_t                shift_q;
    logic [1:0]           state;
    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_idx;
    logic                 bit_end;
    logic                 load;
    logic                 line_bit;

    assign bit_end = (clk_cnt == BIT_CNT_W'(CLK_PER_BIT - 1));
    assign load    = (state == TX_IDLE) && hold_full;

    always_comb
    begin
        case (state)
            TX_START: line_bit = 1'b0;
            TX_DATA:  line_bit = shift_q[0];
            default:  line_bit = 1'b1;      // Idle and stop are mark
        endcase
    end

    always_ff @(posedge i_CLK)
    begin
        if (i_tx_valid)
            hold_q <= i_tx_data;
        if (load)
            shift_q <= hold_q;
        else if ((state == TX_DATA) && bit_end)
            shift_q <= shift_q >> 1;
    end

    always_ff @(posedge i_CLK)
    begin
        if (!i_RST)
        begin
            state       <= TX_IDLE;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            hold_full   <= 1'b0;
            o_tx_credit <= 1'b0;
            o_txd       <= 1'b1;
        end
        else
        begin
            o_txd       <= line_bit;    // Line lags the FSM by one clock
            o_tx_credit <= load;
            if (load)
                hold_full <= 1'b0;
            if (i_tx_valid)
                hold_full <= 1'b1;
            clk_cnt <= ((state == TX_IDLE) || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE:
                begin
                    bit_idx <= '0;
                    if (hold_full)
                        state <= TX_START;
                end
                TX_START:
                begin
                    if (bit_end)
                        state <= TX_DATA;
                end
                TX_DATA:
                begin
                    if (bit_end)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= TX_STOP;
                    end
                end
                default:
                begin
                    if (bit_end)
                        state <= TX_IDLE;
                end
            endcase
        end
    end

    a_no_hold_overrun: assert property (@(posedge i_CLK) disable iff (!i_RST)
        i_tx_valid |-> !hold_full)
        else $error("uart_tx: byte received with holding register full");

endmodule

// File: logic/cmd_engine.sv
`timescale 1ns/100ps

module cmd_engine
(
    input  logic           i_CLK,
    input  logic           i_RST,
    rx_link_if.snk         lnk,
    output logic           o_tx_valid,
    output cmd_pkg::byte_t o_tx_data,
    input  logic           i_tx_credit
);
    import uart_cfg_pkg::*;
    import cmd_pkg::*;

    byte_t                buf_mem [RX_CREDITS];
    logic [RX_PTR_W-1:0]  wr_ptr;
    logic [RX_PTR_W-1:0]  rd_ptr;
    logic [RX_CRED_W-1:0] fill;
    logic [TX_CRED_W-1:0] tx_cred;
    logic [3:0]           key_q;
    logic [6:0]           data_cnt;
    cmd_word_t            head;
    logic                 is_set;
    logic                 is_stat;
    logic                 needs_out;
    logic                 pop;
    logic                 send;

    // Decode the oldest buffered word
    always_comb
    begin
        head      = cmd_word_t'(buf_mem[rd_ptr]);
        is_set    = head.ctl.is_ctl && (head.ctl.op == OP_SET_KEY);
        is_stat   = head.ctl.is_ctl && (head.ctl.op == OP_STATUS);
        needs_out = !head.dat.is_ctl || is_stat;
        pop       = (fill != '0) && (!needs_out || (tx_cred != '0));
        send      = pop && needs_out;
    end

    always_ff @(posedge i_CLK)
    begin
        if (lnk.valid)
            buf_mem[wr_ptr] <= lnk.data;
    end

    always_ff @(posedge i_CLK)
    begin
        if (!i_RST)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            tx_cred    <= TX_CRED_W'(TX_CREDITS);
            key_q      <= '0;
            data_cnt   <= '0;
            lnk.credit <= 1'b0;
            o_tx_valid <= 1'b0;
        end
        else
        begin
            lnk.credit <= pop;          // Hand the freed slot back
            o_tx_valid <= send;
            if (lnk.valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({lnk.valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            case ({send, i_tx_credit})
                2'b10:   tx_cred <= tx_cred - 1'b1;
                2'b01:   tx_cred <= tx_cred + 1'b1;
                default: tx_cred <= tx_cred;
            endcase
            if (pop && is_set)
                key_q <= head.ctl.key;
            if (pop && !head.dat.is_ctl)
                data_cnt <= data_cnt + 1'b1;    // Wraps at 128
        end
    end

    // Output byte is status or scrambled data
    always_ff @(posedge i_CLK)
    begin
        if (send)
        begin
            if (is_stat)
                o_tx_data <= {1'b0, data_cnt};
            else
                o_tx_data <= {1'b0, head.dat.ch[6:4], head.dat.ch[3:0] ^ key_q};
        end
    end

    a_no_push_full: assert property (@(posedge i_CLK) disable iff (!i_RST)
        lnk.valid |-> (fill != RX_CRED_W'(RX_CREDITS)))
        else $error("cmd_engine: word pushed into full buffer");

    a_no_extra_tx_credit: assert property (@(posedge i_CLK) disable iff (!i_RST)
        i_tx_credit |-> (tx_cred != TX_CRED_W'(TX_CREDITS)))
        else $error("cmd_engine: tx credit returned with none outstanding");

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/100ps

module uart_rx
(
    input  logic                              i_CLK,
    input  logic                              i_RST,
    input  logic                              i_rxd,
    output logic [uart_cfg_pkg::ERR_CNT_W-1:0] o_err_cnt,
    rx_link_if.src                            lnk
);
    import uart_cfg_pkg::*;
    import cmd_pkg::*;

    logic [2:0]           state;
    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_idx;
    byte_t                shift_q;
    logic [RX_CRED_W-1:0] credit_q;
    logic                 bit_end;
    logic                 stop_smp;
    logic                 take;
    logic                 err_evt;

    assign bit_end  = (clk_cnt == BIT_CNT_W'(CLK_PER_BIT - 1));
    assign stop_smp = (state == RX_STOP) && bit_end;

    // Stop sample decides the frame outcome
    assign take    = stop_smp && i_rxd && (credit_q != '0);
    assign err_evt = stop_smp && (!i_rxd || (credit_q == '0));

    assign lnk.data = shift_q;

    always_ff @(posedge i_CLK)
    begin
        if (!i_RST)
        begin
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            lnk.valid <= 1'b0;
            lnk.err   <= 1'b0;
        end
        else
        begin
            lnk.valid <= take;
            lnk.err   <= stop_smp && !i_rxd;
            case (state)
                RX_IDLE:
                begin
                    clk_cnt <= '0;
                    if (!i_rxd)
                        state <= RX_START;
                end
                RX_START:
                begin
                    if (clk_cnt == BIT_CNT_W'(HALF_BIT - 1))
                    begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= i_rxd ? RX_IDLE : RX_DATA;  // Glitch goes back
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                RX_DATA:
                begin
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                RX_STOP:
                begin
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end)
                        state <= RX_WAIT;
                end
                default:
                begin
                    if (i_rxd)
                        state <= RX_IDLE;   // Line back to mark
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge i_CLK)
    begin
        if ((state == RX_DATA) && bit_end)
            shift_q <= {i_rxd, shift_q[7:1]};
    end

    always_ff @(posedge i_CLK)
    begin
        if (!i_RST)
        begin
            credit_q  <= RX_CRED_W'(RX_CREDITS);
            o_err_cnt <= '0;
        end
        else
        begin
            case ({take, lnk.credit})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
            if (err_evt && (o_err_cnt != '1))
                o_err_cnt <= o_err_cnt + 1'b1;  // Saturates
        end
    end

    // Engine hands back only credits that were spent
    a_no_extra_credit: assert property (@(posedge i_CLK) disable iff (!i_RST)
        lnk.credit |-> (credit_q != RX_CRED_W'(RX_CREDITS)))
        else $error("uart_rx: credit returned with all credits home");

endmodule

// File: logic/rx_link_if.sv
`timescale 1ns/100ps

interface rx_link_if;
    import cmd_pkg::*;

    logic  valid;   // One cycle per accepted byte
    byte_t data;
    logic  err;     // Framing error pulse
    logic  credit;  // Engine freed one buffer slot

    modport src
    (
        output valid,
        output data,
        output err,
        input  credit
    );

    modport snk
    (
        input  valid,
        input  data,
        input  err,
        output credit
    );

endinterface

// File: logic/cmd_pkg.sv
package cmd_pkg;

    typedef logic [7:0] byte_t;

    // Control view, bit 7 set
    typedef struct packed {
        logic       is_ctl;
        logic [2:0] op;
        logic [3:0] key;
    } ctl_word_t;

    // Data view, bit 7 clear
    typedef struct packed {
        logic       is_ctl;
        logic [6:0] ch;
    } dat_word_t;

    // One received byte, read either way
    typedef union packed {
        ctl_word_t ctl;
        dat_word_t dat;
    } cmd_word_t;

    // Opcodes, anything else is ignored
    localparam logic [2:0] OP_SET_KEY = 3'd0;
    localparam logic [2:0] OP_STATUS  = 3'd1;

endpackage

// File: logic/uart_cfg_pkg.sv
package uart_cfg_pkg;

    // Serial bit timing, kept short for simulation
    localparam int CLK_PER_BIT = 16;
    localparam int HALF_BIT    = CLK_PER_BIT / 2;   // Start bit check point
    localparam int BIT_CNT_W   = $clog2(CLK_PER_BIT);

    // Credit based flow control
    localparam int RX_CREDITS  = 4;                  // Engine buffer depth
    localparam int RX_PTR_W    = $clog2(RX_CREDITS);
    localparam int RX_CRED_W   = $clog2(RX_CREDITS + 1);
    localparam int TX_CREDITS  = 1;                  // Transmitter holding depth
    localparam int TX_CRED_W   = $clog2(TX_CREDITS + 1);

    localparam int ERR_CNT_W   = 8;

    // Receiver FSM codes
    localparam logic [2:0] RX_IDLE  = 3'd0;
    localparam logic [2:0] RX_START = 3'd1;
    localparam logic [2:0] RX_DATA  = 3'd2;
    localparam logic [2:0] RX_STOP  = 3'd3;
    localparam logic [2:0] RX_WAIT  = 3'd4;   // Wait for line high again

    // Transmitter FSM codes
    localparam logic [1:0] TX_IDLE  = 2'd0;
    localparam logic [1:0] TX_START = 2'd1;
    localparam logic [1:0] TX_DATA  = 2'd2;
    localparam logic [1:0] TX_STOP  = 2'd3;

endpackage
